// File: common/vsPkg.sv
////////////////////////////////////////////////////////////////////////////
// Types and constants shared by the arcade input and configuration blocks
// Scan codes are PS/2 set 2 make codes and the extended flag is not decoded
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package vsPkg;

	// Memory and shifter sizes
	localparam int NV_DEPTH    = 2048;
	localparam int SHIFT_WIDTH = 8;
	localparam int DIP_BANKS   = 8;

	// Download stream indexes
	localparam logic [7:0] IDX_ROM0   = 8'd0;
	localparam logic [7:0] IDX_SETUP1 = 8'd1;
	localparam logic [7:0] IDX_SETUP2 = 8'd2;
	localparam logic [7:0] IDX_DIP    = 8'd254;

	// Keyboard scan codes
	localparam logic [7:0] KEY_START1   = 8'h16;
	localparam logic [7:0] KEY_START2   = 8'h1E;
	localparam logic [7:0] KEY_START3   = 8'h26;
	localparam logic [7:0] KEY_START4   = 8'h25;
	localparam logic [7:0] KEY_COIN1    = 8'h2E;
	localparam logic [7:0] KEY_COIN2    = 8'h36;
	localparam logic [7:0] KEY_COIN3    = 8'h3D;
	localparam logic [7:0] KEY_COIN4    = 8'h3E;
	localparam logic [7:0] KEY_SERVICE1 = 8'h46;
	localparam logic [7:0] KEY_SERVICE2 = 8'h45;
	localparam logic [7:0] KEY_UP       = 8'h75;
	localparam logic [7:0] KEY_DOWN     = 8'h72;
	localparam logic [7:0] KEY_LEFT     = 8'h6B;
	localparam logic [7:0] KEY_RIGHT    = 8'h74;
	localparam logic [7:0] KEY_A        = 8'h14;
	localparam logic [7:0] KEY_B        = 8'h11;

	// One USB pad, high bit first
	typedef struct packed {
		logic service;
		logic coin;
		logic start;
		logic select;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	// Held keyboard buttons
	typedef struct packed {
		logic [4:1] start;
		logic [4:1] coin;
		logic [2:1] service;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       a;
		logic       b;
	} keyButtons_t;

	// Keyboard event as delivered by the host
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2Event_t;

	// One beat of the download stream
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  index;
		logic [7:0]  data;
	} download_t;

	// Per-system setup byte, palette field doubles as PPU type
	typedef struct packed {
		logic       reverse;
		logic [2:0] mapper;
		logic [3:0] palette;
	} cartSetup_t;

	// Control outputs of one core
	typedef struct packed {
		logic strobe;
		logic partnerIrq;
		logic spareOut;
		logic nIn0;
		logic nIn1;
	} sysCtrl_t;

	// Battery RAM request of one core
	typedef struct packed {
		logic [10:0] addr;
		logic [7:0]  data;
		logic        wr;
	} nvPort_t;

endpackage

`default_nettype wire

// File: hdl/keyboardDecoder.sv
////////////////////////////////////////////////////////////////////////////
// Key events arrive as a toggle bit that flips once per event
// Extended flag ignored so keypad arrows act as cursor keys too
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module keyboardDecoder (
	input  logic               clk_sys,
	input  logic               reset,
	input  vsPkg::ps2Event_t   ps2Key,
	output vsPkg::keyButtons_t buttons
);
	import vsPkg::*;

	// Previous toggle for change detection
	logic lastToggle;
	logic keyEvent;

	assign keyEvent = ps2Key.toggle != lastToggle;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lastToggle <= 1'b0;
			buttons    <= '0;
		end else begin
			lastToggle <= ps2Key.toggle;
			if (keyEvent) begin
				// Named button follows the pressed flag
				case (ps2Key.code)
					KEY_START1:   buttons.start[1]   <= ps2Key.pressed;
					KEY_START2:   buttons.start[2]   <= ps2Key.pressed;
					KEY_START3:   buttons.start[3]   <= ps2Key.pressed;
					KEY_START4:   buttons.start[4]   <= ps2Key.pressed;
					KEY_COIN1:    buttons.coin[1]    <= ps2Key.pressed;
					KEY_COIN2:    buttons.coin[2]    <= ps2Key.pressed;
					KEY_COIN3:    buttons.coin[3]    <= ps2Key.pressed;
					KEY_COIN4:    buttons.coin[4]    <= ps2Key.pressed;
					KEY_SERVICE1: buttons.service[1] <= ps2Key.pressed;
					KEY_SERVICE2: buttons.service[2] <= ps2Key.pressed;
					// Cursor block
					KEY_UP:       buttons.up         <= ps2Key.pressed;
					KEY_DOWN:     buttons.down       <= ps2Key.pressed;
					KEY_LEFT:     buttons.left       <= ps2Key.pressed;
					KEY_RIGHT:    buttons.right      <= ps2Key.pressed;
					// Ctrl and alt
					KEY_A:        buttons.a          <= ps2Key.pressed;
					KEY_B:        buttons.b          <= ps2Key.pressed;
					// Anything else leaves the buttons alone
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/cartConfig.sv
////////////////////////////////////////////////////////////////////////////
// Setup bytes and DIP banks are written only through the download stream
// Only DIP banks 0 and 1 reach the systems, the rest are kept for loading
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cartConfig (
	input  logic              clk_sys,
	input  logic              reset,
	input  vsPkg::download_t  download,
	input  logic              paletteOverride,
	input  logic [2:0]        paletteSelect,
	output vsPkg::cartSetup_t setup1,
	output vsPkg::cartSetup_t setup2,
	output logic [3:0]        palette1,
	output logic [3:0]        palette2,
	output logic [7:0]        dipSwitch1,
	output logic [7:0]        dipSwitch2
);
	import vsPkg::*;

	// DIP switch banks
	logic [7:0] dipBank [DIP_BANKS];

	// Write decode
	logic setupWr1;
	logic setupWr2;
	logic dipWr;

	assign setupWr1 = download.wr && (download.index == IDX_SETUP1);
	assign setupWr2 = download.wr && (download.index == IDX_SETUP2);
	// Bank number is the low address, upper address must be zero
	assign dipWr = download.wr && (download.index == IDX_DIP)
		&& (download.addr < 25'(DIP_BANKS));

	//////////////////////////////////////////////////////////////////////////
	// Capture registers
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			setup1 <= '0;
			setup2 <= '0;
			for (int i = 0; i < DIP_BANKS; i++) begin
				dipBank[i] <= '0;
			end
		end else begin
			if (setupWr1) begin
				setup1 <= cartSetup_t'(download.data);
			end
			if (setupWr2) begin
				setup2 <= cartSetup_t'(download.data);
			end
			if (dipWr) begin
				dipBank[download.addr[$clog2(DIP_BANKS)-1:0]] <= download.data;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////////

	// Override covers the first eight palettes only
	assign palette1 = paletteOverride ? {1'b0, paletteSelect} : setup1.palette;
	assign palette2 = paletteOverride ? {1'b0, paletteSelect} : setup2.palette;

	// Bank 0 to system 1, bank 1 to system 2
	assign dipSwitch1 = dipBank[0];
	assign dipSwitch2 = dipBank[1];

endmodule

`default_nettype wire

// File: controller/controllerPort.sv
////////////////////////////////////////////////////////////////////////////
// Models the two 8-bit parallel-to-serial button shifters of one system
// nIN clocks are sampled on clk_sys so they must be slow against it
// Keyboard directions and A/B only reach the primary system
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module controllerPort (
	input  logic               clk_sys,
	input  logic               reset,
	input  vsPkg::sysCtrl_t    ctrl,
	input  logic               reverse,
	input  logic               joySwap,
	input  vsPkg::pad_t        padFirst,
	input  vsPkg::pad_t        padSecond,
	input  vsPkg::keyButtons_t keys,
	input  logic               primary,
	output logic [1:0]         serialData,
	output logic               coin1,
	output logic               coin2,
	output logic               service
);
	import vsPkg::*;

	// Pads feeding each port
	pad_t dirPad0;
	pad_t dirPad1;
	pad_t startPad0;
	pad_t startPad1;

	// Keyboard contribution
	logic       kbA;
	logic       kbB;
	logic       kbUp;
	logic       kbDown;
	logic       kbLeft;
	logic       kbRight;
	logic [1:0] kbStart;

	// Shifter state
	logic [SHIFT_WIDTH-1:0] loadValue [2];
	logic [SHIFT_WIDTH-1:0] shiftReg  [2];
	logic [1:0]             clkNow;
	logic [1:0]             clkLast;
	logic [1:0]             clkFall;

	//////////////////////////////////////////////////////////////////////////
	// Player mapping
	//////////////////////////////////////////////////////////////////////////

	// Stick and buttons follow reverse xor swap
	assign dirPad0 = (reverse == joySwap) ? padFirst : padSecond;
	assign dirPad1 = (reverse == joySwap) ? padSecond : padFirst;
	// Start and select follow swap only
	assign startPad0 = joySwap ? padSecond : padFirst;
	assign startPad1 = joySwap ? padFirst : padSecond;

	// Keyboard stick on primary port 0 only
	assign kbA     = primary & keys.a;
	assign kbB     = primary & keys.b;
	assign kbUp    = primary & keys.up;
	assign kbDown  = primary & keys.down;
	assign kbLeft  = primary & keys.left;
	assign kbRight = primary & keys.right;

	// Starts 1/2 on primary, 3/4 on the other
	assign kbStart = primary ? keys.start[2:1] : keys.start[4:3];

	// Shift order A, B, start, select, up, down, left, right
	assign loadValue[0] = {
		dirPad0.a | kbA,
		dirPad0.b | kbB,
		startPad0.start | kbStart[0],
		startPad0.select,
		dirPad0.up | kbUp,
		dirPad0.down | kbDown,
		dirPad0.left | kbLeft,
		dirPad0.right | kbRight
	};
	assign loadValue[1] = {
		dirPad1.a,
		dirPad1.b,
		startPad1.start | kbStart[1],
		startPad1.select,
		dirPad1.up,
		dirPad1.down,
		dirPad1.left,
		dirPad1.right
	};

	//////////////////////////////////////////////////////////////////////////
	// Cabinet signals
	//////////////////////////////////////////////////////////////////////////

	// Coin slots belong to the pads, not the player mapping
	assign coin1   = padFirst.coin | (primary ? keys.coin[1] : keys.coin[3]);
	assign coin2   = padSecond.coin | (primary ? keys.coin[2] : keys.coin[4]);
	assign service = padFirst.service | padSecond.service
		| (primary ? keys.service[1] : keys.service[2]);

	//////////////////////////////////////////////////////////////////////////
	// Shift registers
	//////////////////////////////////////////////////////////////////////////

	// Falling edge of the active-low clocks
	assign clkNow  = {ctrl.nIn1, ctrl.nIn0};
	assign clkFall = clkLast & ~clkNow;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clkLast    <= '0;
			serialData <= '0;
			shiftReg   <= '{default: '0};
		end else begin
			clkLast <= clkNow;
			for (int p = 0; p < 2; p++) begin
				// Shift takes priority over a parallel load
				if (clkFall[p]) begin
					serialData[p] <= shiftReg[p][SHIFT_WIDTH-1];
					// Ones fill in behind the last button
					shiftReg[p] <= {shiftReg[p][SHIFT_WIDTH-2:0], 1'b1};
				end else if (ctrl.strobe) begin
					shiftReg[p] <= loadValue[p];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/nvramShare.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous read RAMs, data one cycle after the address
// Selector is owned by system 1, system 2 also keeps a private copy
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nvramShare (
	input  logic           clk_sys,
	input  logic           sharedRam,
	input  logic           select,
	input  vsPkg::nvPort_t nv1,
	input  vsPkg::nvPort_t nv2,
	output logic [7:0]     nvData1,
	output logic [7:0]     nvData2
);
	import vsPkg::*;

	// Board RAM and the extra one for games that want their own
	logic [7:0] sharedMem  [NV_DEPTH];
	logic [7:0] privateMem [NV_DEPTH];

	nvPort_t    sharedPort;
	logic       sharedWr;
	logic [7:0] sharedQ;
	logic [7:0] privateQ;

	//////////////////////////////////////////////////////////////////////////
	// Shared RAM select
	//////////////////////////////////////////////////////////////////////////

	// Select low hands address and data to system 2
	assign sharedPort = select ? nv1 : nv2;

	// Without sharing only system 1 may write
	assign sharedWr = sharedRam ? sharedPort.wr : nv1.wr;

	always_ff @(posedge clk_sys) begin
		if (sharedWr) begin
			sharedMem[sharedPort.addr] <= sharedPort.data;
		end
		sharedQ <= sharedMem[sharedPort.addr];
	end

	//////////////////////////////////////////////////////////////////////////
	// Private RAM of system 2
	//////////////////////////////////////////////////////////////////////////

	// Always written so it stays current when sharing is turned off
	always_ff @(posedge clk_sys) begin
		if (nv2.wr) begin
			privateMem[nv2.addr] <= nv2.data;
		end
		privateQ <= privateMem[nv2.addr];
	end

	// Read data back to the cores
	assign nvData1 = sharedQ;
	assign nvData2 = sharedRam ? sharedQ : privateQ;

endmodule

`default_nettype wire

// File: hdl/vsArcadeIo.sv
////////////////////////////////////////////////////////////////////////////
// Input and configuration side of a dual-system arcade board
// System 1 is primary and owns the shared RAM select and keyboard stick
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vsArcadeIo (
	input  logic              clk_sys,
	input  logic              reset,
	input  vsPkg::ps2Event_t  ps2Key,
	input  vsPkg::pad_t       padA,
	input  vsPkg::pad_t       padB,
	input  vsPkg::pad_t       padC,
	input  vsPkg::pad_t       padD,
	input  vsPkg::download_t  download,
	input  logic              joySwap,
	input  logic              sharedRam,
	input  logic              paletteOverride,
	input  logic [2:0]        paletteSelect,
	input  vsPkg::sysCtrl_t   sys1Ctrl,
	input  vsPkg::sysCtrl_t   sys2Ctrl,
	input  vsPkg::nvPort_t    nv1,
	input  vsPkg::nvPort_t    nv2,
	output logic [1:0]        serialData1,
	output logic [1:0]        serialData2,
	output logic              sys1Coin1,
	output logic              sys1Coin2,
	output logic              sys1Service,
	output logic              sys2Coin1,
	output logic              sys2Coin2,
	output logic              sys2Service,
	output logic [3:0]        palette1,
	output logic [3:0]        palette2,
	output logic [3:0]        ppuType1,
	output logic [3:0]        ppuType2,
	output logic [2:0]        mapper1,
	output logic [2:0]        mapper2,
	output logic [7:0]        dipSwitch1,
	output logic [7:0]        dipSwitch2,
	output logic [7:0]        nvData1,
	output logic [7:0]        nvData2
);
	import vsPkg::*;

	keyButtons_t keys;
	cartSetup_t  setup1;
	cartSetup_t  setup2;

	keyboardDecoder i_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2Key  (ps2Key),
		.buttons (keys)
	);

	cartConfig i_cart (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.download        (download),
		.paletteOverride (paletteOverride),
		.paletteSelect   (paletteSelect),
		.setup1          (setup1),
		.setup2          (setup2),
		.palette1        (palette1),
		.palette2        (palette2),
		.dipSwitch1      (dipSwitch1),
		.dipSwitch2      (dipSwitch2)
	);

	// PPU type ignores the palette override
	assign ppuType1 = setup1.palette;
	assign ppuType2 = setup2.palette;
	assign mapper1  = setup1.mapper;
	assign mapper2  = setup2.mapper;

	// System 1 on pads A/B
	controllerPort i_port1 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ctrl       (sys1Ctrl),
		.reverse    (setup1.reverse),
		.joySwap    (joySwap),
		.padFirst   (padA),
		.padSecond  (padB),
		.keys       (keys),
		.primary    (1'b1),
		.serialData (serialData1),
		.coin1      (sys1Coin1),
		.coin2      (sys1Coin2),
		.service    (sys1Service)
	);

	// System 2 on pads C/D
	controllerPort i_port2 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ctrl       (sys2Ctrl),
		.reverse    (setup2.reverse),
		.joySwap    (joySwap),
		.padFirst   (padC),
		.padSecond  (padD),
		.keys       (keys),
		.primary    (1'b0),
		.serialData (serialData2),
		.coin1      (sys2Coin1),
		.coin2      (sys2Coin2),
		.service    (sys2Service)
	);

	// OUT1 of system 1 drives the RAM selector
	nvramShare i_nvram (
		.clk_sys   (clk_sys),
		.sharedRam (sharedRam),
		.select    (sys1Ctrl.partnerIrq),
		.nv1       (nv1),
		.nv2       (nv2),
		.nvData1   (nvData1),
		.nvData2   (nvData2)
	);

endmodule

`default_nettype wire

// File: tb/vsArcadeIo_checker.sv
////////////////////////////////////////////////////////////////////////////
// Assertions on the top level, sampled at clk_sys
// Setup bytes are reached through the bind scope, not through ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vsArcadeIo_checker (
	input logic              clk_sys,
	input logic              reset,
	input vsPkg::pad_t       padA,
	input logic              sys1Coin1,
	input logic              paletteOverride,
	input logic [2:0]        paletteSelect,
	input logic [3:0]        palette1,
	input logic [1:0]        serialData1,
	input logic [1:0]        serialData2,
	input vsPkg::cartSetup_t setup1,
	input vsPkg::cartSetup_t setup2
);

	// Cleared state one cycle into reset
	assert property (@(posedge clk_sys) reset |=> (serialData1 == '0 && serialData2 == '0
		&& setup1 == '0 && setup2 == '0))
		else $error("serial outputs or setup bytes not cleared by reset");

	// Override forces the low palettes
	assert property (@(posedge clk_sys) disable iff (reset)
		paletteOverride |-> (palette1 == {1'b0, paletteSelect}))
		else $error("palette1 ignores the palette override");

	// Pad coin always reaches the cabinet
	assert property (@(posedge clk_sys) disable iff (reset) padA.coin |-> sys1Coin1)
		else $error("padA coin not seen on system 1 coin1");

endmodule

bind vsArcadeIo vsArcadeIo_checker i_checker (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.padA            (padA),
	.sys1Coin1       (sys1Coin1),
	.paletteOverride (paletteOverride),
	.paletteSelect   (paletteSelect),
	.palette1        (palette1),
	.serialData1     (serialData1),
	.serialData2     (serialData2),
	.setup1          (setup1),
	.setup2          (setup2)
);

`default_nettype wire

// File: tb/vsArcadeIo_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed tests for the dual-system arcade input block
// Keyboard stick and start keys are held from test 4 to the end of the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vsArcadeIo_tb;
	import vsPkg::*;

	// Five serial reads of about 40 cycles plus key, download and RAM beats
	localparam int MAX_CYCLES = 2000;

	logic        clk_sys;
	logic        reset;
	ps2Event_t   ps2Key;
	pad_t        padA;
	pad_t        padB;
	pad_t        padC;
	pad_t        padD;
	download_t   download;
	logic        joySwap;
	logic        sharedRam;
	logic        paletteOverride;
	logic [2:0]  paletteSelect;
	sysCtrl_t    sys1Ctrl;
	sysCtrl_t    sys2Ctrl;
	nvPort_t     nv1;
	nvPort_t     nv2;
	logic [1:0]  serialData1;
	logic [1:0]  serialData2;
	logic        sys1Coin1;
	logic        sys1Coin2;
	logic        sys1Service;
	logic        sys2Coin1;
	logic        sys2Coin2;
	logic        sys2Service;
	logic [3:0]  palette1;
	logic [3:0]  palette2;
	logic [3:0]  ppuType1;
	logic [3:0]  ppuType2;
	logic [2:0]  mapper1;
	logic [2:0]  mapper2;
	logic [7:0]  dipSwitch1;
	logic [7:0]  dipSwitch2;
	logic [7:0]  nvData1;
	logic [7:0]  nvData2;

	int          cycleCount = 0;
	// Setup bytes as last written
	logic [7:0]  setupByte1;
	logic [7:0]  setupByte2;

	vsArcadeIo i_dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ps2Key          (ps2Key),
		.padA            (padA),
		.padB            (padB),
		.padC            (padC),
		.padD            (padD),
		.download        (download),
		.joySwap         (joySwap),
		.sharedRam       (sharedRam),
		.paletteOverride (paletteOverride),
		.paletteSelect   (paletteSelect),
		.sys1Ctrl        (sys1Ctrl),
		.sys2Ctrl        (sys2Ctrl),
		.nv1             (nv1),
		.nv2             (nv2),
		.serialData1     (serialData1),
		.serialData2     (serialData2),
		.sys1Coin1       (sys1Coin1),
		.sys1Coin2       (sys1Coin2),
		.sys1Service     (sys1Service),
		.sys2Coin1       (sys2Coin1),
		.sys2Coin2       (sys2Coin2),
		.sys2Service     (sys2Service),
		.palette1        (palette1),
		.palette2        (palette2),
		.ppuType1        (ppuType1),
		.ppuType2        (ppuType2),
		.mapper1         (mapper1),
		.mapper2         (mapper2),
		.dipSwitch1      (dipSwitch1),
		.dipSwitch2      (dipSwitch2),
		.nvData1         (nvData1),
		.nvData2         (nvData2)
	);

	// 8 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycleCount++;
		if (cycleCount >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////////

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %0h actual %0h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	function automatic logic [7:0] randomByte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic pad_t randomPad();
		logic [31:0] r;
		r = $urandom;
		return r[9:0];
	endfunction

	// Expected shifter byte, A first
	function automatic logic [7:0] mapByte(input pad_t dirPad, input pad_t startPad,
		input logic startKey);
		return {dirPad.a, dirPad.b, startPad.start | startKey, startPad.select,
			dirPad.up, dirPad.down, dirPad.left, dirPad.right};
	endfunction

	// One key event, returns once the button level is visible
	task automatic sendKey(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2Key <= {~ps2Key.toggle, pressed, 1'b0, code};
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic writeDownload(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		download <= {1'b1, addr, index, data};
		@(posedge clk_sys);
		download <= '0;
		@(negedge clk_sys);
	endtask

	// Strobe and both nIN lines of one system
	task automatic setCtrl(input int sys, input logic strobe, input logic nIn);
		@(posedge clk_sys);
		if (sys == 1) begin
			sys1Ctrl.strobe <= strobe;
			sys1Ctrl.nIn0   <= nIn;
			sys1Ctrl.nIn1   <= nIn;
		end else begin
			sys2Ctrl.strobe <= strobe;
			sys2Ctrl.nIn0   <= nIn;
			sys2Ctrl.nIn1   <= nIn;
		end
	endtask

	// Latch, then eight falling edges and one extra
	task automatic readSerial(input int sys, output logic [7:0] rx0,
		output logic [7:0] rx1, output logic [1:0] extra);
		logic [1:0] bits;
		rx0 = '0;
		rx1 = '0;
		setCtrl(sys, 1'b1, 1'b1);
		setCtrl(sys, 1'b0, 1'b1);
		for (int i = 0; i < 8; i++) begin
			setCtrl(sys, 1'b0, 1'b0);
			setCtrl(sys, 1'b0, 1'b1);
			@(negedge clk_sys);
			bits = (sys == 1) ? serialData1 : serialData2;
			rx0 = {rx0[6:0], bits[0]};
			rx1 = {rx1[6:0], bits[1]};
		end
		setCtrl(sys, 1'b0, 1'b0);
		setCtrl(sys, 1'b0, 1'b1);
		@(negedge clk_sys);
		extra = (sys == 1) ? serialData1 : serialData2;
	endtask

	task automatic checkSerial(input string name, input int sys, input logic rev,
		input pad_t first, input pad_t second, input logic startKey);
		pad_t       dir0;
		pad_t       dir1;
		pad_t       start0;
		pad_t       start1;
		logic [7:0] rx0;
		logic [7:0] rx1;
		logic [1:0] extra;
		readSerial(sys, rx0, rx1, extra);
		// Stick follows reverse against swap, start follows swap
		dir0   = (rev == joySwap) ? first : second;
		dir1   = (rev == joySwap) ? second : first;
		start0 = joySwap ? second : first;
		start1 = joySwap ? first : second;
		compareValue($sformatf("%s port0", name), mapByte(dir0, start0, startKey), rx0);
		compareValue($sformatf("%s port1", name), mapByte(dir1, start1, startKey), rx1);
		compareValue($sformatf("%s ninth", name), 2'b11, extra);
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////////

	task automatic testKeyboard();
		sendKey(KEY_COIN1, 1'b1);
		compareValue("keyboard press", 1, sys1Coin1);
		sendKey(KEY_COIN1, 1'b0);
		compareValue("keyboard release", 0, sys1Coin1);
		// Enter is not a cabinet key
		sendKey(8'h5A, 1'b1);
		compareValue("keyboard unknown", 6'b0, {sys1Coin1, sys1Coin2, sys1Service,
			sys2Coin1, sys2Coin2, sys2Service});
	endtask

	task automatic testSetupCapture();
		logic [7:0] dip0;
		logic [7:0] dip1;
		logic [7:0] tmp;
		setupByte1 = randomByte();
		setupByte2 = randomByte();
		dip0 = randomByte();
		dip1 = randomByte();
		writeDownload(IDX_SETUP1, 25'd0, setupByte1);
		writeDownload(IDX_SETUP2, 25'd0, setupByte2);
		writeDownload(IDX_DIP, 25'd0, dip0);
		writeDownload(IDX_DIP, 25'd1, dip1);
		compareValue("setup palette1", setupByte1[3:0], palette1);
		compareValue("setup ppuType1", setupByte1[3:0], ppuType1);
		compareValue("setup mapper1", setupByte1[6:4], mapper1);
		compareValue("setup palette2", setupByte2[3:0], palette2);
		compareValue("setup ppuType2", setupByte2[3:0], ppuType2);
		compareValue("setup mapper2", setupByte2[6:4], mapper2);
		compareValue("dip bank0", dip0, dipSwitch1);
		compareValue("dip bank1", dip1, dipSwitch2);
		tmp = randomByte();
		@(posedge clk_sys);
		paletteOverride <= 1'b1;
		paletteSelect   <= tmp[2:0];
		@(posedge clk_sys);
		@(negedge clk_sys);
		compareValue("override palette1", {1'b0, tmp[2:0]}, palette1);
		compareValue("override palette2", {1'b0, tmp[2:0]}, palette2);
		compareValue("override ppuType1", setupByte1[3:0], ppuType1);
		@(posedge clk_sys);
		paletteOverride <= 1'b0;
	endtask

	task automatic testSerial();
		logic rev;
		logic swap;
		pad_t pa;
		pad_t pb;
		for (int combo = 0; combo < 4; combo++) begin
			rev  = combo[0];
			swap = combo[1];
			pa   = randomPad();
			pb   = randomPad();
			setupByte1 = {rev, setupByte1[6:0]};
			writeDownload(IDX_SETUP1, 25'd0, setupByte1);
			@(posedge clk_sys);
			joySwap <= swap;
			padA    <= pa;
			padB    <= pb;
			checkSerial($sformatf("serial rev%0d swap%0d", rev, swap), 1, rev, pa, pb, 1'b0);
		end
	endtask

	task automatic testSecondSystem();
		pad_t pc;
		pad_t pd;
		// Pads keep only service, coin, start and select
		pc = randomPad() & 10'h3C0;
		pd = randomPad() & 10'h3C0;
		sendKey(KEY_START3, 1'b1);
		sendKey(KEY_START4, 1'b1);
		sendKey(KEY_UP, 1'b1);
		sendKey(KEY_LEFT, 1'b1);
		sendKey(KEY_A, 1'b1);
		@(posedge clk_sys);
		padC <= pc;
		padD <= pd;
		checkSerial("system2", 2, setupByte2[7], pc, pd, 1'b1);
	endtask

	task automatic testNvram();
		logic [31:0] r;
		logic [10:0] addr;
		logic [7:0]  d1;
		logic [7:0]  d2;
		r    = $urandom;
		addr = r[10:0];
		d1   = randomByte();
		d2   = ~d1;
		// System 1 owns the RAM and writes
		@(posedge clk_sys);
		sharedRam           <= 1'b1;
		sys1Ctrl.partnerIrq <= 1'b1;
		nv1                 <= {addr, d1, 1'b1};
		@(posedge clk_sys);
		nv1.wr <= 1'b0;
		// Hand over to system 2 and read back
		@(posedge clk_sys);
		sys1Ctrl.partnerIrq <= 1'b0;
		nv2                 <= {addr, 8'h00, 1'b0};
		@(posedge clk_sys);
		@(negedge clk_sys);
		compareValue("nvram shared read", d1, nvData2);
		// Private write with sharing off
		@(posedge clk_sys);
		sharedRam <= 1'b0;
		nv2       <= {addr, d2, 1'b1};
		@(posedge clk_sys);
		nv2.wr              <= 1'b0;
		sys1Ctrl.partnerIrq <= 1'b1;
		nv1                 <= {addr, 8'h00, 1'b0};
		@(posedge clk_sys);
		@(negedge clk_sys);
		compareValue("nvram system1 keeps", d1, nvData1);
		compareValue("nvram private read", d2, nvData2);
	endtask

	initial begin
		void'($urandom(54));
		reset           = 1'b1;
		ps2Key          = '0;
		padA            = '0;
		padB            = '0;
		padC            = '0;
		padD            = '0;
		download        = '0;
		joySwap         = 1'b0;
		sharedRam       = 1'b0;
		paletteOverride = 1'b0;
		paletteSelect   = '0;
		// Shift clocks idle high
		sys1Ctrl        = 5'b00011;
		sys2Ctrl        = 5'b00011;
		nv1             = '0;
		nv2             = '0;
		setupByte1      = '0;
		setupByte2      = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		testKeyboard();
		testSetupCapture();
		testSerial();
		testSecondSystem();
		testNvram();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/vsPkg.sv
hdl/keyboardDecoder.sv
hdl/cartConfig.sv
controller/controllerPort.sv
hdl/nvramShare.sv
hdl/vsArcadeIo.sv
tb/vsArcadeIo_checker.sv
tb/vsArcadeIo_tb.sv

// File: Bender.yml
package:
  name: vs_arcade_io

sources:
  - common/vsPkg.sv
  - hdl/keyboardDecoder.sv
  - hdl/cartConfig.sv
  - controller/controllerPort.sv
  - hdl/nvramShare.sv
  - hdl/vsArcadeIo.sv
  - target: test
    files:
      - tb/vsArcadeIo_checker.sv
      - tb/vsArcadeIo_tb.sv
